// File: include/xif_dma_defines.svh
/*
 * XIF DMA control definitions
 * Data and address widths, instruction field positions and the
 * byte offsets of the DMA front-end configuration registers
 */

`ifndef XIF_DMA_DEFINES_SVH
`define XIF_DMA_DEFINES_SVH

// **************************************
// Data paths
// **************************************

`define XIF_DMA_DATA_W  32
`define XIF_DMA_ADDR_W  32
`define XIF_DMA_INSTR_W 32

// **************************************
// Instruction fields
// **************************************

`define XIF_DMA_OPCODE_OFF 0
`define XIF_DMA_OPCODE_W   7
`define XIF_DMA_FUNC3_OFF  12   // Only meaningful for the SET opcode
`define XIF_DMA_FUNC3_W    3
`define XIF_DMA_DIR_OFF    31   // 0 moves toward local memory, 1 moves away from it
`define XIF_DMA_DIR_W      1
`define XIF_DMA_CONF_OFF   19   // Packed transfer options of the CONF instruction
`define XIF_DMA_CONF_W     12

// **************************************
// DMA front-end register map
// **************************************

`define XIF_DMA_REG_CONF_OFF     32'h0000_0000
`define XIF_DMA_REG_DST_ADDR_OFF 32'h0000_0004
`define XIF_DMA_REG_SRC_ADDR_OFF 32'h0000_0008
`define XIF_DMA_REG_LENGTH_OFF   32'h0000_000C
`define XIF_DMA_REG_NEXT_ID_OFF  32'h0000_0010  // Reading it launches the transfer
`define XIF_DMA_REG_DONE_ID_OFF  32'h0000_0014

`endif

// File: hdl/xif_dma_isa_pkg.sv
/*
 * XIF DMA instruction set types
 * Opcode and function encodings, the coprocessor issue handshake
 * payloads and the decoded update that goes to the register bank
 */

`include "xif_dma_defines.svh"

package xif_dma_isa_pkg;

  // Custom opcode space of the core
  typedef enum logic [`XIF_DMA_OPCODE_W-1:0] {
    CONF = 7'b101_1011,
    SET  = 7'b010_1011
  } dma_opcode_e;

  // Function field of the SET opcode
  typedef enum logic [`XIF_DMA_FUNC3_W-1:0] {
    SET_DA = 3'd0,  // Destination address
    SET_SA = 3'd1,  // Source address
    SET_L  = 3'd2,  // Length in bytes
    SET_S  = 3'd3   // Start the transfer
  } dma_func3_e;

  // Issue request from the core
  typedef struct packed {
    logic [`XIF_DMA_INSTR_W-1:0] instr;
    logic [`XIF_DMA_DATA_W-1:0]  rs0;
    logic                        rs_valid;  // Operand rs0 has been read
  } xif_issue_req_t;

  // Issue response back to the core
  typedef struct packed {
    logic accept;
  } xif_issue_rsp_t;

  // One cycle update of the staged configuration
  typedef struct packed {
    logic                       conf_we;
    logic                       dst_we;
    logic                       src_we;
    logic                       len_we;
    logic [`XIF_DMA_DATA_W-1:0] conf;       // Zero extended option field
    logic                       direction;
    logic [`XIF_DMA_DATA_W-1:0] value;      // Operand for the SET writes
  } cfg_update_t;

endpackage

// File: hdl/xif_dma_reg_pkg.sv
/*
 * XIF DMA register port types
 * Request and response of the DMA front-end configuration port,
 * the staged register bank and the sequencer states
 */

`include "xif_dma_defines.svh"

package xif_dma_reg_pkg;

  // Register request, held stable until ready
  typedef struct packed {
    logic [`XIF_DMA_ADDR_W-1:0] addr;
    logic                       write;
    logic [`XIF_DMA_DATA_W-1:0] wdata;
    logic                       valid;
  } dma_reg_req_t;

  // Register response, valid in the cycle of ready
  typedef struct packed {
    logic [`XIF_DMA_DATA_W-1:0] rdata;
    logic                       ready;
    logic                       error;
  } dma_reg_rsp_t;

  // Staged transfer configuration
  typedef struct packed {
    logic [`XIF_DMA_DATA_W-1:0] conf;
    logic                       direction;
    logic [`XIF_DMA_DATA_W-1:0] dst;
    logic [`XIF_DMA_DATA_W-1:0] src;
    logic [`XIF_DMA_DATA_W-1:0] len;
  } cfg_bank_t;

  // Front-end sequencer states
  typedef enum logic [3:0] {
    IDLE,
    WR_CFG, WR_DST, WR_SRC, WR_LEN,  // Configuration writes in map order
    START,                           // NEXT_ID read launches the transfer
    BUSY,                            // DONE_ID polling
    DONE
  } fe_state_e;

endpackage

// File: hdl/xif_dma_inst_decoder.sv
/*
 * XIF DMA instruction decoder
 * Classifies issued instructions, drives the issue handshake and
 * turns accepted CONF and SET instructions into bank updates
 */

`timescale 1ns/1ps

`include "xif_dma_defines.svh"

module xif_dma_inst_decoder
  import xif_dma_isa_pkg::*;
(
  input  logic           clk_cfg_g,
  input  logic           rst_ni,
  input  logic           issue_valid_i,
  input  xif_issue_req_t issue_req_i,
  output logic           issue_ready_o,
  output xif_issue_rsp_t issue_rsp_o,
  input  logic           start_pending_i,  // A transfer is waiting or running
  output cfg_update_t    cfg_update_o,
  output logic           start_req_o
);

  dma_opcode_e                opcode;
  dma_func3_e                 func3;
  logic [`XIF_DMA_CONF_W-1:0] conf_field;
  logic                       dir_bit;
  logic                       start_req_q;
  logic                       start_block;

  assign opcode     = dma_opcode_e'(issue_req_i.instr[`XIF_DMA_OPCODE_OFF +: `XIF_DMA_OPCODE_W]);
  assign func3      = dma_func3_e'(issue_req_i.instr[`XIF_DMA_FUNC3_OFF +: `XIF_DMA_FUNC3_W]);
  assign conf_field = issue_req_i.instr[`XIF_DMA_CONF_OFF +: `XIF_DMA_CONF_W];
  assign dir_bit    = issue_req_i.instr[`XIF_DMA_DIR_OFF +: `XIF_DMA_DIR_W];

  // A start just handed to the bank also blocks, so a second SET_S never
  // depends on when the bank latch becomes visible
  always_ff @(posedge clk_cfg_g or negedge rst_ni) begin
    if (!rst_ni) begin
      start_req_q <= 1'b0;
    end else begin
      start_req_q <= start_req_o;
    end
  end

  assign start_block = start_pending_i | start_req_q;

  always_comb begin : decode
    issue_ready_o          = 1'b0;
    issue_rsp_o            = '0;
    start_req_o            = 1'b0;
    cfg_update_o           = '0;
    cfg_update_o.conf      = {{(`XIF_DMA_DATA_W - `XIF_DMA_CONF_W){1'b0}}, conf_field};
    cfg_update_o.direction = dir_bit;
    cfg_update_o.value     = issue_req_i.rs0;

    if (issue_valid_i) begin
      case (opcode)
        CONF: begin
          issue_ready_o        = 1'b1;
          issue_rsp_o.accept   = 1'b1;
          cfg_update_o.conf_we = 1'b1;
        end
        SET: begin
          issue_rsp_o.accept = 1'b1;
          case (func3)
            SET_DA: begin
              issue_ready_o       = issue_req_i.rs_valid;  // Wait for the operand
              cfg_update_o.dst_we = issue_req_i.rs_valid;
            end
            SET_SA: begin
              issue_ready_o       = issue_req_i.rs_valid;
              cfg_update_o.src_we = issue_req_i.rs_valid;
            end
            SET_L: begin
              issue_ready_o       = issue_req_i.rs_valid;
              cfg_update_o.len_we = issue_req_i.rs_valid;
            end
            SET_S: begin
              issue_ready_o = ~start_block;  // One transfer at a time
              start_req_o   = ~start_block;
            end
            default: begin
              issue_ready_o      = 1'b1;  // Unknown function is refused
              issue_rsp_o.accept = 1'b0;
            end
          endcase
        end
        default: issue_ready_o = 1'b1;  // Not ours, answer at once with accept low
      endcase
    end
  end

endmodule

// File: hdl/xif_dma_cfg_regs.sv
/*
 * XIF DMA configuration register bank
 * Holds the staged transfer registers and the start latch between
 * the decoder and the front-end sequencer
 */

`timescale 1ns/1ps

module xif_dma_cfg_regs
  import xif_dma_isa_pkg::*;
  import xif_dma_reg_pkg::*;
(
  input  logic        clk_cfg_g,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  cfg_update_t cfg_update_i,
  input  logic        start_req_i,
  input  logic        start_ack_i,
  output cfg_bank_t   cfg_bank_o,
  output logic        start_pending_o
);

  cfg_bank_t bank_q;
  logic      pending_q;

  // Staged registers, each with its own enable
  always_ff @(posedge clk_cfg_g or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_q <= '0;
    end else if (clear_i) begin
      bank_q <= '0;
    end else begin
      if (cfg_update_i.conf_we) begin
        bank_q.conf      <= cfg_update_i.conf;
        bank_q.direction <= cfg_update_i.direction;
      end
      if (cfg_update_i.dst_we) bank_q.dst <= cfg_update_i.value;
      if (cfg_update_i.src_we) bank_q.src <= cfg_update_i.value;
      if (cfg_update_i.len_we) bank_q.len <= cfg_update_i.value;
    end
  end

  // **************************************
  // Start latch
  // **************************************

  // Set by SET_S and held until the sequencer closes the transfer
  always_ff @(posedge clk_cfg_g or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (clear_i) begin
      pending_q <= 1'b0;
    end else if (start_req_i) begin
      pending_q <= 1'b1;  // A new request wins over a same cycle acknowledge
    end else if (start_ack_i) begin
      pending_q <= 1'b0;
    end
  end

  assign cfg_bank_o      = bank_q;
  assign start_pending_o = pending_q;

endmodule

// File: hdl/xif_dma_fe_sequencer.sv
/*
 * XIF DMA front-end sequencer
 * Writes the staged registers to the DMA configuration port, reads
 * the transfer ID, polls for completion and reports status
 */

`timescale 1ns/1ps

`include "xif_dma_defines.svh"

module xif_dma_fe_sequencer
  import xif_dma_reg_pkg::*;
(
  input  logic         clk_cfg_g,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  cfg_bank_t    cfg_bank_i,
  input  logic         start_pending_i,
  output logic         start_ack_o,
  output dma_reg_req_t reg_req_o,
  input  dma_reg_rsp_t reg_rsp_i,
  output logic         start_o,
  output logic         busy_o,
  output logic         done_o,
  output logic         error_o
);

  fe_state_e                  state_q, state_d;
  logic [`XIF_DMA_DATA_W-1:0] next_id_q, next_id_d;

  logic [`XIF_DMA_ADDR_W-1:0] wr_addr;
  logic [`XIF_DMA_DATA_W-1:0] wr_data;
  fe_state_e                  wr_next;

  // **************************************
  // Write target of each write state
  // **************************************

  always_comb begin : wr_target
    wr_addr = `XIF_DMA_REG_CONF_OFF;
    wr_data = cfg_bank_i.conf;
    wr_next = WR_DST;
    case (state_q)
      WR_DST: begin
        wr_addr = `XIF_DMA_REG_DST_ADDR_OFF;
        wr_data = cfg_bank_i.dst;
        wr_next = WR_SRC;
      end
      WR_SRC: begin
        wr_addr = `XIF_DMA_REG_SRC_ADDR_OFF;
        wr_data = cfg_bank_i.src;
        wr_next = WR_LEN;
      end
      WR_LEN: begin
        wr_addr = `XIF_DMA_REG_LENGTH_OFF;
        wr_data = cfg_bank_i.len;
        wr_next = START;
      end
      default: ;  // WR_CFG keeps the defaults
    endcase
  end

  // **************************************
  // Sequencer FSM
  // **************************************

  always_comb begin : fe_fsm
    state_d     = state_q;
    next_id_d   = next_id_q;
    reg_req_o   = '0;
    start_ack_o = 1'b0;
    start_o     = 1'b0;
    busy_o      = 1'b0;
    done_o      = 1'b0;
    error_o     = 1'b0;

    case (state_q)
      IDLE: begin
        if (start_pending_i) state_d = WR_CFG;
      end
      WR_CFG, WR_DST, WR_SRC, WR_LEN: begin
        reg_req_o.addr  = wr_addr;
        reg_req_o.write = 1'b1;
        reg_req_o.wdata = wr_data;
        reg_req_o.valid = 1'b1;
        if (reg_rsp_i.ready) begin
          if (reg_rsp_i.error) begin
            error_o     = 1'b1;
            start_ack_o = 1'b1;  // Transfer is abandoned
            state_d     = IDLE;
          end else begin
            state_d = wr_next;
          end
        end
      end
      START: begin
        start_o         = 1'b1;
        reg_req_o.addr  = `XIF_DMA_REG_NEXT_ID_OFF;
        reg_req_o.valid = 1'b1;
        if (reg_rsp_i.ready) begin
          // A zero ID means the front-end refused the configuration
          if (reg_rsp_i.error || reg_rsp_i.rdata == '0) begin
            error_o     = 1'b1;
            start_ack_o = 1'b1;
            state_d     = IDLE;
          end else begin
            next_id_d = reg_rsp_i.rdata;
            state_d   = BUSY;
          end
        end
      end
      BUSY: begin
        busy_o          = 1'b1;
        reg_req_o.addr  = `XIF_DMA_REG_DONE_ID_OFF;
        reg_req_o.valid = 1'b1;
        if (reg_rsp_i.ready) begin
          if (reg_rsp_i.error) begin
            error_o     = 1'b1;
            start_ack_o = 1'b1;
            state_d     = IDLE;
          end else if (reg_rsp_i.rdata == next_id_q) begin
            state_d = DONE;  // Our transfer has completed
          end
        end
      end
      DONE: begin
        done_o      = 1'b1;
        start_ack_o = 1'b1;  // Frees the latch for the next SET_S
        state_d     = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_cfg_g or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      next_id_q <= `XIF_DMA_DATA_W'(1);
    end else if (clear_i) begin
      state_q   <= IDLE;
      next_id_q <= `XIF_DMA_DATA_W'(1);
    end else begin
      state_q   <= state_d;
      next_id_q <= next_id_d;
    end
  end

endmodule

// File: hdl/xif_dma_ctrl.sv
/*
 * XIF DMA control top level
 * Connects the instruction decoder, the configuration register bank
 * and the front-end sequencer
 */

`timescale 1ns/1ps

module xif_dma_ctrl
  import xif_dma_isa_pkg::*;
  import xif_dma_reg_pkg::*;
(
  input  logic           clk_cfg_g,
  input  logic           rst_ni,
  input  logic           clear_i,
  input  logic           issue_valid_i,
  input  xif_issue_req_t issue_req_i,
  output logic           issue_ready_o,
  output xif_issue_rsp_t issue_rsp_o,
  output dma_reg_req_t   reg_req_o,
  input  dma_reg_rsp_t   reg_rsp_i,
  output logic           direction_o,  // Direction bit of the last CONF
  output logic           start_o,
  output logic           busy_o,
  output logic           done_o,
  output logic           error_o
);

  cfg_update_t cfg_update;
  logic        start_req;
  logic        start_ack;
  logic        start_pending;
  cfg_bank_t   cfg_bank;

  xif_dma_inst_decoder u_decoder (
    .clk_cfg_g       (clk_cfg_g),
    .rst_ni          (rst_ni),
    .issue_valid_i   (issue_valid_i),
    .issue_req_i     (issue_req_i),
    .issue_ready_o   (issue_ready_o),
    .issue_rsp_o     (issue_rsp_o),
    .start_pending_i (start_pending),
    .cfg_update_o    (cfg_update),
    .start_req_o     (start_req)
  );

  xif_dma_cfg_regs u_cfg_regs (
    .clk_cfg_g       (clk_cfg_g),
    .rst_ni          (rst_ni),
    .clear_i         (clear_i),
    .cfg_update_i    (cfg_update),
    .start_req_i     (start_req),
    .start_ack_i     (start_ack),
    .cfg_bank_o      (cfg_bank),
    .start_pending_o (start_pending)
  );

  xif_dma_fe_sequencer u_sequencer (
    .clk_cfg_g       (clk_cfg_g),
    .rst_ni          (rst_ni),
    .clear_i         (clear_i),
    .cfg_bank_i      (cfg_bank),
    .start_pending_i (start_pending),
    .start_ack_o     (start_ack),
    .reg_req_o       (reg_req_o),
    .reg_rsp_i       (reg_rsp_i),
    .start_o         (start_o),
    .busy_o          (busy_o),
    .done_o          (done_o),
    .error_o         (error_o)
  );

  assign direction_o = cfg_bank.direction;

endmodule

// File: test/xif_dma_ctrl_sva.sv
/*
 * XIF DMA control port assertions
 * Bound to the top level, checks the register port handshake and
 * the shape of the status pulses
 */

`timescale 1ns/1ps

module xif_dma_ctrl_sva
  import xif_dma_reg_pkg::*;
(
  input logic         clk_cfg_g,
  input logic         rst_ni,
  input logic         clear_i,
  input dma_reg_req_t reg_req_o,
  input dma_reg_rsp_t reg_rsp_i,
  input logic         start_o,
  input logic         busy_o,
  input logic         done_o,
  input logic         error_o
);

  int fails = 0;  // Assertion failures so far

  // **************************************
  // Register port handshake
  // **************************************

  a_req_held: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni || clear_i)
    reg_req_o.valid && !reg_rsp_i.ready |=> $stable(reg_req_o))
    else begin
      $error("register request changed while ready was low");
      fails++;
    end

  // Done closes the transfer and drops the request
  a_done_pulse: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni)
    done_o |=> !done_o && !reg_req_o.valid)
    else begin
      $error("done_o longer than one cycle or request still valid after it");
      fails++;
    end

  a_error_pulse: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni)
    error_o |=> !error_o)
    else begin
      $error("error_o longer than one cycle");
      fails++;
    end

  a_reset_quiet: assert property (@(posedge clk_cfg_g)
    $rose(rst_ni) |-> !reg_req_o.valid && !start_o && !busy_o && !done_o && !error_o)
    else begin
      $error("outputs active right after reset");
      fails++;
    end

endmodule

// File: test/tb_xif_dma_ctrl.sv
/*
 * XIF DMA control testbench
 * Issues DMA instructions, models the DMA front-end register port
 * and checks write order, transfer tracking, errors and clear
 */

`timescale 1ns/1ps

`include "xif_dma_defines.svh"

module tb_xif_dma_ctrl
  import xif_dma_isa_pkg::*;
  import xif_dma_reg_pkg::*;
();

  localparam int max_cycles = 2000;  // Six tests of at most about 300 cycles plus margin

  logic           clk_cfg_g = 1'b0;
  logic           rst_ni;
  logic           clear;
  logic           issue_valid;
  xif_issue_req_t issue_req;
  logic           issue_ready;
  xif_issue_rsp_t issue_rsp;
  dma_reg_req_t   reg_req;
  dma_reg_rsp_t   reg_rsp = '0;
  logic           direction;
  logic           start;
  logic           busy;
  logic           done;
  logic           error;

  // Front-end model state
  logic [31:0] wr_addr_q[$];
  logic [31:0] wr_data_q[$];
  logic [31:0] id_next = 32'd1;
  logic [31:0] issued_id = '0;
  dma_reg_req_t held_req = '0;
  int          wait_cnt = 0;
  int          polls_left = 0;
  bit          done_matched = 1'b0;
  int          err_mode = 0;  // 0 normal, 1 error on the SRC write, 2 zero NEXT_ID

  bit seen_start = 1'b0;
  int done_cnt = 0;
  int error_cnt = 0;
  int req_cycles = 0;
  int check_fails = 0;
  int fails_at = 0;
  int passed_tests = 0;
  int failed_tests = 0;
  int cycles = 0;

  always #2 clk_cfg_g = ~clk_cfg_g;

  always @(posedge clk_cfg_g) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Run stopped after %0d cycles with tests still running", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  xif_dma_ctrl DUT (
    .clk_cfg_g     (clk_cfg_g),
    .rst_ni        (rst_ni),
    .clear_i       (clear),
    .issue_valid_i (issue_valid),
    .issue_req_i   (issue_req),
    .issue_ready_o (issue_ready),
    .issue_rsp_o   (issue_rsp),
    .reg_req_o     (reg_req),
    .reg_rsp_i     (reg_rsp),
    .direction_o   (direction),
    .start_o       (start),
    .busy_o        (busy),
    .done_o        (done),
    .error_o       (error)
  );

  bind xif_dma_ctrl xif_dma_ctrl_sva u_sva (.*);

  // **************************************
  // DMA front-end model
  // **************************************

  always @(posedge clk_cfg_g) begin
    #0.5;
    if (reg_rsp.ready) begin  // The handshake finished on this edge
      if (held_req.write) begin
        wr_addr_q.push_back(held_req.addr);
        wr_data_q.push_back(held_req.wdata);
      end else if (held_req.addr == `XIF_DMA_REG_NEXT_ID_OFF) begin
        if (reg_rsp.rdata != 0) begin
          issued_id    = reg_rsp.rdata;
          id_next      = id_next + 32'd1;
          polls_left   = $urandom_range(3, 0);
          done_matched = 1'b0;
        end
      end else if (reg_rsp.rdata == issued_id) begin
        done_matched = 1'b1;
      end else begin
        polls_left--;
      end
    end
    reg_rsp = '0;
    if (reg_req.valid) begin
      if (wait_cnt > 0) begin
        wait_cnt--;  // Back-pressure
      end else begin
        held_req      = reg_req;
        wait_cnt      = $urandom_range(3, 0);
        reg_rsp.ready = 1'b1;
        if (reg_req.write)
          reg_rsp.error = (err_mode == 1) && (reg_req.addr == `XIF_DMA_REG_SRC_ADDR_OFF);
        else if (reg_req.addr == `XIF_DMA_REG_NEXT_ID_OFF)
          reg_rsp.rdata = (err_mode == 2) ? 32'd0 : id_next;
        else
          reg_rsp.rdata = (polls_left <= 0) ? issued_id : issued_id - 32'd1;
      end
    end
  end

  // Status monitor sampled at the falling edge
  always @(negedge clk_cfg_g) begin
    if (rst_ni) begin
      if (reg_req.valid) req_cycles++;
      if (start) seen_start = 1'b1;
      if (busy) begin
        expect_true(seen_start, "busy_o rose before start_o");
        expect_true(!done_matched, "busy_o still high after DONE_ID matched");
      end
      if (done) begin
        done_cnt++;
        expect_true(done_matched, "done_o pulsed before DONE_ID matched");
      end
      if (error) error_cnt++;
    end
  end

  // **************************************
  // Checks and stimulus helpers
  // **************************************

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
      check_fails++;
    end
  endtask

  task automatic expect_true(input bit cond, input string what);
    assert (cond) else begin
      $display("** Error: %s", what);
      check_fails++;
    end
  endtask

  function automatic logic [31:0] conf_instr(input logic dir, input logic [11:0] field);
    logic [31:0] instr;
    instr = '0;
    instr[`XIF_DMA_OPCODE_OFF +: `XIF_DMA_OPCODE_W] = CONF;
    instr[`XIF_DMA_CONF_OFF +: `XIF_DMA_CONF_W]     = field;
    instr[`XIF_DMA_DIR_OFF]                         = dir;
    return instr;
  endfunction

  function automatic logic [31:0] set_instr(input dma_func3_e func);
    logic [31:0] instr;
    instr = '0;
    instr[`XIF_DMA_OPCODE_OFF +: `XIF_DMA_OPCODE_W] = SET;
    instr[`XIF_DMA_FUNC3_OFF +: `XIF_DMA_FUNC3_W]   = func;
    return instr;
  endfunction

  // Holds the request until ready, then drops valid after the handshake edge
  task automatic issue(input logic [31:0] instr, input logic [31:0] rs0, output logic acc);
    issue_req   = {instr, rs0, 1'b1};
    issue_valid = 1'b1;
    do @(negedge clk_cfg_g); while (!issue_ready);
    acc = issue_rsp.accept;
    @(posedge clk_cfg_g);
    #0.5;
    issue_valid = 1'b0;
  endtask

  task automatic issue_ok(input logic [31:0] instr, input logic [31:0] rs0);
    logic acc;
    issue(instr, rs0, acc);
    expect_true(acc, "instruction was not accepted");
  endtask

  task automatic program_transfer(input logic dir, input logic [11:0] conf,
                                  input logic [31:0] dst, src, len);
    issue_ok(conf_instr(dir, conf), '0);
    issue_ok(set_instr(SET_DA), dst);
    issue_ok(set_instr(SET_SA), src);
    issue_ok(set_instr(SET_L), len);
    issue_ok(set_instr(SET_S), '0);
  endtask

  task automatic wait_end();
    do @(negedge clk_cfg_g); while (!(done || error));
    @(posedge clk_cfg_g);
    #0.5;
    seen_start = 1'b0;
  endtask

  task automatic check_writes(input logic [31:0] conf, dst, src, len);
    logic [31:0] exp_addr [4];
    logic [31:0] exp_data [4];
    exp_addr = '{`XIF_DMA_REG_CONF_OFF, `XIF_DMA_REG_DST_ADDR_OFF,
                 `XIF_DMA_REG_SRC_ADDR_OFF, `XIF_DMA_REG_LENGTH_OFF};
    exp_data = '{conf, dst, src, len};
    expect_eq("register write count", 32'(wr_addr_q.size()), 32'd4);
    for (int i = 0; i < 4 && i < wr_addr_q.size(); i++) begin
      expect_eq("reg_req_o.addr", wr_addr_q[i], exp_addr[i]);
      expect_eq("reg_req_o.wdata", wr_data_q[i], exp_data[i]);
    end
  endtask

  // An aborted transfer gives one error pulse and then a quiet port
  task automatic check_abort();
    int snap;
    expect_eq("error_o pulses", 32'(error_cnt), 32'd1);
    expect_eq("done_o pulses", 32'(done_cnt), 32'd0);
    snap = req_cycles;
    repeat (20) @(posedge clk_cfg_g);
    #0.5;
    expect_eq("reg_req_o.valid cycles after error", 32'(req_cycles - snap), 32'd0);
  endtask

  task automatic begin_test();
    wr_addr_q.delete();
    wr_data_q.delete();
    done_cnt   = 0;
    error_cnt  = 0;
    seen_start = 1'b0;
    fails_at   = check_fails + DUT.u_sva.fails;
  endtask

  task automatic end_test(input string name);
    if (check_fails + DUT.u_sva.fails == fails_at) begin
      passed_tests++;
      $display("test %-18s ok", name);
    end else begin
      failed_tests++;
      $display("test %-18s failed", name);
    end
  endtask

  // **************************************
  // Test sequence
  // **************************************

  initial begin : stim
    logic [11:0] conf_v;
    logic [31:0] dst_v;
    logic [31:0] src_v;
    logic [31:0] len_v;
    logic        acc;

    void'($urandom(32'h8f20));
    rst_ni      = 1'b0;
    clear       = 1'b0;
    issue_valid = 1'b0;
    issue_req   = '0;
    repeat (16) @(posedge clk_cfg_g);
    #0.5;
    rst_ni = 1'b1;
    expect_true(!issue_ready && !reg_req.valid, "handshake outputs active after reset");

    begin_test();
    conf_v = 12'($urandom());
    dst_v  = $urandom();
    src_v  = $urandom();
    len_v  = $urandom();
    program_transfer(1'b1, conf_v, dst_v, src_v, len_v);
    wait_end();
    check_writes({20'd0, conf_v}, dst_v, src_v, len_v);
    expect_eq("direction_o", 32'(direction), 32'd1);
    expect_eq("done_o pulses", 32'(done_cnt), 32'd1);
    end_test("write_sequence");

    begin_test();
    conf_v = 12'($urandom());
    dst_v  = $urandom();
    src_v  = $urandom();
    len_v  = $urandom();
    program_transfer(1'b1, conf_v, dst_v, src_v, len_v);
    wait_end();
    check_writes({20'd0, conf_v}, dst_v, src_v, len_v);
    expect_eq("done_o pulses", 32'(done_cnt), 32'd1);
    expect_eq("error_o pulses", 32'(error_cnt), 32'd0);
    end_test("transfer_tracking");

    begin_test();
    err_mode = 1;
    program_transfer(1'b1, 12'h0a5, $urandom(), $urandom(), $urandom());
    wait_end();
    check_abort();
    err_mode = 0;
    end_test("error_response");

    begin_test();
    err_mode = 2;
    issue_ok(set_instr(SET_S), '0);
    wait_end();
    check_abort();
    err_mode = 0;
    end_test("zero_next_id");

    begin_test();
    issue_ok(conf_instr(1'b0, 12'h3c1), '0);
    expect_eq("direction_o", 32'(direction), 32'd0);
    issue(32'h0000_0013, '0, acc);  // An OP-IMM instruction belongs to the core
    expect_true(!acc, "unknown opcode was accepted");
    issue_ok(set_instr(SET_S), '0);
    issue_ok(set_instr(SET_S), '0);  // Stalls until the first transfer is done
    expect_eq("done_o pulses before second start", 32'(done_cnt), 32'd1);
    wait_end();
    expect_eq("done_o pulses", 32'(done_cnt), 32'd2);
    end_test("direction_reject");

    // Direction set so that the clear has something to bring back to zero
    issue_ok(conf_instr(1'b1, 12'h5a3), '0);
    clear = 1'b1;
    @(posedge clk_cfg_g);
    #0.5;
    clear = 1'b0;
    begin_test();
    issue_ok(set_instr(SET_S), '0);
    wait_end();
    check_writes('0, '0, '0, '0);
    expect_eq("direction_o", 32'(direction), 32'd0);
    end_test("clear");

    $display("tests passed %0d, tests failed %0d, check failures %0d, assertion failures %0d",
             passed_tests, failed_tests, check_fails, DUT.u_sva.fails);
    if (failed_tests == 0 && check_fails + DUT.u_sva.fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: xif_dma_ctrl.f
+incdir+include
hdl/xif_dma_isa_pkg.sv
hdl/xif_dma_reg_pkg.sv
hdl/xif_dma_inst_decoder.sv
hdl/xif_dma_cfg_regs.sv
hdl/xif_dma_fe_sequencer.sv
hdl/xif_dma_ctrl.sv
test/xif_dma_ctrl_sva.sv
test/tb_xif_dma_ctrl.sv

// File: run.sh
#!/bin/sh
# Build and run the XIF DMA control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f xif_dma_ctrl.f --top-module tb_xif_dma_ctrl -o sim_tb

# The simulator status is not trusted, the log decides
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
